/* design/l2_cache_pkg.sv */
`default_nettype none

package l2_cache_pkg;

	//**************************************************************************
	// Cache geometry
	//**************************************************************************

	localparam int addr_width  = 32;
	localparam int line_width  = 256;
	localparam int offset_bits = 5;   // 32-byte lines.
	localparam int index_bits  = 3;
	localparam int tag_bits    = addr_width - index_bits - offset_bits;
	localparam int num_sets    = 1 << index_bits;

	typedef logic [line_width-1:0] line_t;
	typedef logic [tag_bits-1:0]   tag_t;
	typedef logic [index_bits-1:0] index_t;

	//**************************************************************************
	// Controller states
	//**************************************************************************

	typedef enum logic [1:0]
	{
		hit_idle,    // Waiting for a request.
		hit_check,   // Tag compare on the latched address.
		evict,       // Dirty victim going out.
		allocate     // Refill from memory.
	} l2_state_t;

	//**************************************************************************
	// Request buses
	//**************************************************************************

	// From the L1, held until mem_resp.
	typedef struct packed
	{
		logic                  read;
		logic                  write;
		logic [addr_width-1:0] address;
		line_t                 wdata;
	} l2_req_t;

	// To memory, held until pmem_resp.
	typedef struct packed
	{
		logic                  read;
		logic                  write;
		logic [addr_width-1:0] address;   // Line aligned.
		line_t                 wdata;
	} pmem_req_t;

endpackage

`default_nettype wire

/* design/l2_cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control
	import l2_cache_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         mem_read,
	input  wire         mem_write,
	input  wire         pmem_resp,
	input  wire         cache_hit,
	input  wire         dirtyout,
	output logic        pmem_read,
	output logic        pmem_write,
	output logic        mem_resp,
	output logic        datain_mux_sel,
	output logic        write_enable,
	output logic        valid_in,
	output logic        cache_allocate,
	output logic        dirty_datain,
	output logic        pmem_address_sel,
	output logic        addr_reg_load,
	output logic        evict_allocate,
	output logic [31:0] miss_count
);

	l2_state_t state;
	l2_state_t next_state;

	//**************************************************************************
	// Next state
	//**************************************************************************

	always_comb
	begin
		next_state = state;
		case (state)
			hit_idle:
			begin
				if (mem_read || mem_write)
					next_state = hit_check;
			end
			hit_check:
			begin
				if (cache_hit)
					next_state = hit_idle;
				else if (dirtyout)
					next_state = evict;
				else
					next_state = allocate;
			end
			evict:
			begin
				if (pmem_resp)
					next_state = allocate;   // Victim written, now refill.
			end
			allocate:
			begin
				if (pmem_resp)
					next_state = hit_idle;   // Request retried from idle.
			end
			default:
				next_state = hit_idle;
		endcase
	end

	//**************************************************************************
	// State outputs
	//**************************************************************************

	always_comb
	begin
		pmem_read        = 1'b0;
		pmem_write       = 1'b0;
		mem_resp         = 1'b0;
		datain_mux_sel   = 1'b0;
		write_enable     = 1'b0;
		valid_in         = 1'b0;
		cache_allocate   = 1'b0;
		dirty_datain     = 1'b0;
		pmem_address_sel = 1'b0;
		addr_reg_load    = 1'b0;
		evict_allocate   = 1'b0;
		case (state)
			hit_idle:
			begin
				addr_reg_load = 1'b1;
			end
			hit_check:
			begin
				evict_allocate = 1'b1;
				if (cache_hit)
				begin
					mem_resp = 1'b1;
					if (mem_write)
					begin
						// Write hit updates the line and marks it dirty.
						write_enable   = 1'b1;
						valid_in       = 1'b1;
						dirty_datain   = 1'b1;
						datain_mux_sel = 1'b1;
					end
				end
			end
			evict:
			begin
				evict_allocate   = 1'b1;
				pmem_address_sel = 1'b1;   // Victim address.
				pmem_write       = 1'b1;
			end
			allocate:
			begin
				evict_allocate = 1'b1;
				pmem_read      = 1'b1;
				if (pmem_resp)
				begin
					write_enable   = 1'b1;
					valid_in       = 1'b1;
					cache_allocate = 1'b1;   // New tag, clean line.
				end
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= hit_idle;
			miss_count <= '0;
		end
		else
		begin
			state <= next_state;
			if (next_state == allocate && state != allocate)
				miss_count <= miss_count + 32'd1;   // One per refill.
		end
	end

	//**************************************************************************
	// Checks
	//**************************************************************************

	assert property (@(posedge clk) disable iff (reset)
		!(pmem_read && pmem_write));

	// Hit response lasts one cycle.
	assert property (@(posedge clk) disable iff (reset)
		mem_resp |-> cache_hit ##1 !mem_resp);

	assert property (@(posedge clk) disable iff (reset)
		(pmem_read || pmem_write) && !pmem_resp |=> $stable({pmem_read, pmem_write}));

endmodule

`default_nettype wire

/* design/l2_cache_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_datapath
	import l2_cache_pkg::*;
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire l2_req_t          req,
	input  wire line_t            pmem_rdata,
	input  wire                   addr_reg_load,
	input  wire                   evict_allocate,
	input  wire                   write_enable,
	input  wire                   valid_in,
	input  wire                   dirty_datain,
	input  wire                   datain_mux_sel,
	input  wire                   cache_allocate,
	input  wire                   pmem_address_sel,
	output logic                  cache_hit,
	output logic                  dirtyout,
	output line_t                 mem_rdata,
	output logic [addr_width-1:0] pmem_address,
	output line_t                 pmem_wdata
);

	logic [addr_width-1:0] addr_reg;
	logic [addr_width-1:0] lookup_addr;
	tag_t                  lookup_tag;
	index_t                index;
	line_t                 datain;

	tag_t                  tag_array [num_sets];
	line_t                 data_array [num_sets];
	logic [num_sets-1:0]   valid_array;
	logic [num_sets-1:0]   dirty_array;

	tag_t                  stored_tag;
	logic                  stored_valid;

	//**************************************************************************
	// Address selection
	//**************************************************************************

	always_ff @(posedge clk)
	begin
		if (addr_reg_load)
			addr_reg <= req.address;
	end

	// Live request while idle, latched address otherwise.
	assign lookup_addr = evict_allocate ? addr_reg : req.address;
	assign lookup_tag  = lookup_addr[addr_width-1 -: tag_bits];
	assign index       = lookup_addr[offset_bits +: index_bits];

	//**************************************************************************
	// Arrays
	//**************************************************************************

	assign datain = datain_mux_sel ? req.wdata : pmem_rdata;

	always_ff @(posedge clk)
	begin
		if (write_enable)
			data_array[index] <= datain;
		if (write_enable && cache_allocate)
			tag_array[index] <= lookup_tag;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_array <= '0;
			dirty_array <= '0;
		end
		else if (write_enable)
		begin
			valid_array[index] <= valid_in;
			dirty_array[index] <= dirty_datain;
		end
	end

	//**************************************************************************
	// Lookup and output muxes
	//**************************************************************************

	assign stored_tag   = tag_array[index];
	assign stored_valid = valid_array[index];

	assign cache_hit = stored_valid && (stored_tag == lookup_tag);
	assign dirtyout  = stored_valid && dirty_array[index];

	assign mem_rdata  = data_array[index];
	assign pmem_wdata = data_array[index];   // Victim line.

	always_comb
	begin
		if (pmem_address_sel)
			pmem_address = {stored_tag, index, {offset_bits{1'b0}}};
		else
			pmem_address = {lookup_tag, index, {offset_bits{1'b0}}};
	end

	// Lookup must resolve once the valid bits are cleared.
	assert property (@(posedge clk) disable iff (reset)
		!$isunknown(cache_hit));

endmodule

`default_nettype wire

/* design/l2_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache
	import l2_cache_pkg::*;
(
	input  wire              clk,
	input  wire              reset,
	input  wire l2_req_t     req,
	input  wire line_t       pmem_rdata,
	input  wire              pmem_resp,
	output line_t            mem_rdata,
	output logic             mem_resp,
	output pmem_req_t        pmem_req,
	output logic [31:0]      miss_count
);

	logic                  pmem_read;
	logic                  pmem_write;
	logic                  datain_mux_sel;
	logic                  write_enable;
	logic                  valid_in;
	logic                  cache_allocate;
	logic                  dirty_datain;
	logic                  pmem_address_sel;
	logic                  addr_reg_load;
	logic                  evict_allocate;
	logic                  cache_hit;
	logic                  dirtyout;
	logic [addr_width-1:0] pmem_address;
	line_t                 pmem_wdata;

	l2_cache_control u_control
	(
		.clk              (clk),
		.reset            (reset),
		.mem_read         (req.read),
		.mem_write        (req.write),
		.pmem_resp        (pmem_resp),
		.cache_hit        (cache_hit),
		.dirtyout         (dirtyout),
		.pmem_read        (pmem_read),
		.pmem_write       (pmem_write),
		.mem_resp         (mem_resp),
		.datain_mux_sel   (datain_mux_sel),
		.write_enable     (write_enable),
		.valid_in         (valid_in),
		.cache_allocate   (cache_allocate),
		.dirty_datain     (dirty_datain),
		.pmem_address_sel (pmem_address_sel),
		.addr_reg_load    (addr_reg_load),
		.evict_allocate   (evict_allocate),
		.miss_count       (miss_count)
	);

	l2_cache_datapath u_datapath
	(
		.clk              (clk),
		.reset            (reset),
		.req              (req),
		.pmem_rdata       (pmem_rdata),
		.addr_reg_load    (addr_reg_load),
		.evict_allocate   (evict_allocate),
		.write_enable     (write_enable),
		.valid_in         (valid_in),
		.dirty_datain     (dirty_datain),
		.datain_mux_sel   (datain_mux_sel),
		.cache_allocate   (cache_allocate),
		.pmem_address_sel (pmem_address_sel),
		.cache_hit        (cache_hit),
		.dirtyout         (dirtyout),
		.mem_rdata        (mem_rdata),
		.pmem_address     (pmem_address),
		.pmem_wdata       (pmem_wdata)
	);

	// Memory bus.
	assign pmem_req = '{
		read:    pmem_read,
		write:   pmem_write,
		address: pmem_address,
		wdata:   pmem_wdata
	};

endmodule

`default_nettype wire

/* test/pmem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module pmem_model
	import l2_cache_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire pmem_req_t pmem_req,
	output line_t          pmem_rdata,
	output logic           pmem_resp
);

	line_t                              mem [logic [addr_width-offset_bits-1:0]];
	logic [addr_width-1:0]              last_write_addr;
	line_t                              last_write_data;
	logic [addr_width-offset_bits-1:0]  line_addr;
	integer                             seed;
	logic                               busy;
	int unsigned                        remaining;

	// Every word depends on the full line address.
	function automatic line_t fill_line(logic [addr_width-offset_bits-1:0] addr);
		line_t line;
		for (int k = 0; k < 8; k++)
			line[k*32 +: 32] = ({addr, k[4:0]} * 32'h9e37_79b9) ^ 32'h81f3_0000;
		return line;
	endfunction

	initial
	begin
		seed       = 32'h81f3;
		pmem_resp  = 1'b0;
		pmem_rdata = '0;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			busy      <= 1'b0;
			remaining <= 0;
			pmem_resp <= 1'b0;
		end
		else
		begin
			pmem_resp <= 1'b0;
			line_addr = pmem_req.address[addr_width-1:offset_bits];
			if (!busy && !pmem_resp && (pmem_req.read || pmem_req.write))
			begin
				busy      <= 1'b1;
				remaining <= $unsigned($random(seed)) % 4;   // 1 to 4 cycles.
			end
			else if (busy && remaining != 0)
				remaining <= remaining - 1;
			else if (busy)
			begin
				busy      <= 1'b0;
				pmem_resp <= 1'b1;
				if (pmem_req.read)
					pmem_rdata <= mem.exists(line_addr) ? mem[line_addr] : fill_line(line_addr);
				else
				begin
					mem[line_addr] = pmem_req.wdata;
					last_write_addr <= pmem_req.address;
					last_write_data <= pmem_req.wdata;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* test/l2_cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb
	import l2_cache_pkg::*;
();

	localparam int num_lines  = 24;
	localparam int num_trans  = 300;
	localparam int resp_limit = 100;

	logic        clk;
	logic        reset;
	l2_req_t     req;
	line_t       mem_rdata;
	logic        mem_resp;
	pmem_req_t   pmem_req;
	line_t       pmem_rdata;
	logic        pmem_resp;
	logic [31:0] miss_count;

	integer      seed;
	int          errors;
	int          checks;
	logic        timed_out;
	int          expected_misses;
	int          pmem_writes;
	int          pmem_reads;
	int          reads_at_last_write;

	line_t       shadow_mem [num_lines];
	logic        shadow_valid [num_sets];
	logic        shadow_dirty [num_sets];
	int          shadow_line [num_sets];   // Line number held by each set.

	l2_cache u_dut
	(
		.clk        (clk),
		.reset      (reset),
		.req        (req),
		.pmem_rdata (pmem_rdata),
		.pmem_resp  (pmem_resp),
		.mem_rdata  (mem_rdata),
		.mem_resp   (mem_resp),
		.pmem_req   (pmem_req),
		.miss_count (miss_count)
	);

	pmem_model u_pmem
	(
		.clk        (clk),
		.reset      (reset),
		.pmem_req   (pmem_req),
		.pmem_rdata (pmem_rdata),
		.pmem_resp  (pmem_resp)
	);

	always #50 clk = ~clk;

	// Memory traffic seen on the downstream port.
	always @(posedge clk)
	begin
		if (reset)
		begin
			pmem_writes <= 0;
			pmem_reads  <= 0;
		end
		else if (pmem_resp)
		begin
			if (pmem_req.write)
			begin
				pmem_writes         <= pmem_writes + 1;
				reads_at_last_write <= pmem_reads;
			end
			if (pmem_req.read)
				pmem_reads <= pmem_reads + 1;
		end
	end

	//**************************************************************************
	// Reference values
	//**************************************************************************

	function automatic logic [addr_width-1:0] line_address(int n);
		return 32'h0004_0000 + 32'(n) * 32;
	endfunction

	function automatic line_t initial_line(logic [addr_width-offset_bits-1:0] addr);
		line_t line;
		for (int k = 0; k < 8; k++)
			line[k*32 +: 32] = ({addr, k[4:0]} * 32'h9e37_79b9) ^ 32'h81f3_0000;
		return line;
	endfunction

	task automatic check_equal(string name, logic [255:0] got, logic [255:0] expected);
		checks++;
		assert (got == expected)
		else
		begin
			errors++;
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, expected);
		end
	endtask

	task automatic check_reset_outputs();
		checks++;
		assert (!mem_resp && !pmem_req.read && !pmem_req.write
			&& u_dut.u_control.state == hit_idle)
		else
		begin
			errors++;
			$display("Controller not idle during reset at %0t", $time);
		end
		check_equal("miss_count", miss_count, 0);
	endtask

	//**************************************************************************
	// One request and its checks
	//**************************************************************************

	task automatic run_transaction(int n, logic is_write, line_t wdata);
		int         set;
		int         victim;
		int         cycles;
		int         reads_before;
		int         writes_before;
		logic       hit;
		logic       writeback;
		logic       pmem_seen;
		logic [4:0] offset;
		l2_req_t    next_req;

		set           = n % num_sets;
		victim        = shadow_line[set];
		hit           = shadow_valid[set] && victim == n;
		writeback     = !hit && shadow_valid[set] && shadow_dirty[set];
		expected_misses += hit ? 0 : 1;
		reads_before  = pmem_reads;
		writes_before = pmem_writes;
		pmem_seen     = 1'b0;
		cycles        = 0;
		offset        = 5'($random(seed));
		next_req      = '{read: !is_write, write: is_write,
			address: line_address(n) + 32'(offset), wdata: wdata};
		req <= next_req;
		do
		begin
			@(posedge clk);
			cycles++;
			if (pmem_req.read || pmem_req.write)
				pmem_seen = 1'b1;
		end
		while (!mem_resp && cycles < resp_limit);
		if (!mem_resp)
		begin
			errors++;
			timed_out = 1'b1;
			$display("No mem_resp within %0d cycles for line %0d at %0t", resp_limit, n, $time);
			return;
		end
		if (!is_write)
			check_equal("mem_rdata", mem_rdata, shadow_mem[n]);
		check_equal("miss_count", miss_count, expected_misses);
		if (hit)
		begin
			check_equal("hit latency", cycles, 2);
			check_equal("pmem activity on hit", pmem_seen, 0);
		end
		else
		begin
			check_equal("pmem reads", pmem_reads - reads_before, 1);
			check_equal("pmem writes", pmem_writes - writes_before, writeback ? 1 : 0);
			if (writeback)
			begin
				check_equal("pmem write address", u_pmem.last_write_addr, line_address(victim));
				check_equal("pmem write data", u_pmem.last_write_data, shadow_mem[victim]);
				check_equal("reads before write-back", reads_at_last_write, reads_before);
			end
		end
		shadow_valid[set] = 1'b1;
		shadow_line[set]  = n;
		if (is_write)
		begin
			shadow_mem[n]     = wdata;
			shadow_dirty[set] = 1'b1;
		end
		else if (!hit)
			shadow_dirty[set] = 1'b0;   // Fresh refill.
	endtask

	//**************************************************************************
	// Main sequence
	//**************************************************************************

	initial
	begin
		int    n;
		logic  is_write;
		line_t wdata;

		seed            = 32'h81f3;
		errors          = 0;
		checks          = 0;
		timed_out       = 1'b0;
		expected_misses = 0;
		clk             = 1'b0;
		reset           = 1'b1;
		req             = '0;
		for (int i = 0; i < num_lines; i++)
			shadow_mem[i] = initial_line((addr_width-offset_bits)'(line_address(i) >> offset_bits));
		for (int s = 0; s < num_sets; s++)
		begin
			shadow_valid[s] = 1'b0;
			shadow_dirty[s] = 1'b0;
			shadow_line[s]  = 0;
		end
		for (int c = 1; c <= 5; c++)
		begin
			@(posedge clk);
			if (c > 1)
				check_reset_outputs();
		end
		reset <= 1'b0;
		@(posedge clk);
		check_reset_outputs();
		for (int t = 0; t < num_trans && !timed_out; t++)
		begin
			n        = $unsigned($random(seed)) % num_lines;
			is_write = 1'($random(seed));
			for (int k = 0; k < 8; k++)
				wdata[k*32 +: 32] = $random(seed);
			if (($random(seed) & 7) == 0)
			begin
				req <= '0;   // Idle gap.
				@(posedge clk);
			end
			run_transaction(n, is_write, wdata);
		end
		req <= '0;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
design/l2_cache_pkg.sv
design/l2_cache_control.sv
design/l2_cache_datapath.sv
design/l2_cache.sv
test/pmem_model.sv
test/l2_cache_tb.sv

/* run.sh */
#!/bin/sh
# Build the L2 cache testbench with Verilator, run it, then scan the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module l2_cache_tb \
	-o l2_cache_sim > build.log 2>&1 \
	&& ./obj_dir/l2_cache_sim > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error, see build.log and sim.log" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
